/* common/pipe_ctrl_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// pipeline control package: stage indices, exception codes, CP0 bit fields
// and exception vector offsets shared by the stall/flush/redirect controller
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

package pipe_ctrl_pkg;

    // five-stage in-order pipeline
    localparam int num_stages = 5;

    // bit index of each stage in every stall / flush vector
    localparam int stage_if  = 0;
    localparam int stage_id  = 1;
    localparam int stage_ex  = 2;
    localparam int stage_mem = 3;
    localparam int stage_wb  = 4;

    // exception type as reported by the MEM stage
    typedef enum logic [4:0] {
        // no exception pending
        exc_none = 5'd0,
        // external or software interrupt
        exc_intr = 5'd1,
        // TLB refill, has its own vector while EXL is clear
        exc_tlbr = 5'd2,
        // general class, all go to the general vector
        exc_ri   = 5'd3,
        exc_ov   = 5'd4,
        exc_trap = 5'd5,
        exc_sysc = 5'd6,
        exc_bp   = 5'd7,
        exc_ade  = 5'd8,
        exc_tlbi = 5'd9,
        exc_tlbm = 5'd10,
        exc_cpu  = 5'd11,
        // return from exception, redirect to EPC or ErrorEPC
        exc_eret = 5'd12
    } exc_t;

    // Status register fields
    // boot exception vectors
    localparam int status_bev = 22;
    // exception level
    localparam int status_exl = 1;
    // error level, selects ErrorEPC on ERET
    localparam int status_erl = 2;

    // Cause register fields
    // special interrupt vector enable
    localparam int cause_iv = 23;

    // offsets added to the selected vector base
    // TLB refill while EXL clear
    localparam logic [31:0] off_refill  = 32'h0000_0000;
    // general exceptions
    localparam logic [31:0] off_general = 32'h0000_0180;
    // interrupts when IV is set
    localparam logic [31:0] off_intr    = 32'h0000_0200;

endpackage

`default_nettype wire

/* src/stall_resolver.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// stall resolver that ripples per-stage stall requests back toward IF and
// marks the stages that must take a bubble while their predecessor is held
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`default_nettype none

module stall_resolver (
    input  wire logic [pipe_ctrl_pkg::num_stages-1:0] stall_req,
    input  wire logic                                 ex_null,
    input  wire logic                                 mem_null,
    output logic      [pipe_ctrl_pkg::num_stages-1:0] stall_norm,
    output logic      [pipe_ctrl_pkg::num_stages-1:0] bubble_flush
);

    always_comb begin
        // evaluated from WB toward IF so there is no combinational loop
        stall_norm[pipe_ctrl_pkg::stage_wb]  = stall_req[pipe_ctrl_pkg::stage_wb];
        stall_norm[pipe_ctrl_pkg::stage_mem] = stall_req[pipe_ctrl_pkg::stage_mem] |
                                               stall_norm[pipe_ctrl_pkg::stage_wb];
        // an empty MEM slot soaks up a stall from below
        stall_norm[pipe_ctrl_pkg::stage_ex]  = stall_req[pipe_ctrl_pkg::stage_ex] |
                                               stall_req[pipe_ctrl_pkg::stage_if] |
                                               (stall_norm[pipe_ctrl_pkg::stage_mem] &
                                                ~mem_null);
        // same for an empty EX slot
        stall_norm[pipe_ctrl_pkg::stage_id]  = stall_req[pipe_ctrl_pkg::stage_id] |
                                               stall_req[pipe_ctrl_pkg::stage_if] |
                                               (stall_norm[pipe_ctrl_pkg::stage_ex] &
                                                ~ex_null);
        // fetch never runs ahead of decode
        stall_norm[pipe_ctrl_pkg::stage_if]  = stall_norm[pipe_ctrl_pkg::stage_id];
    end

    always_comb begin
        // front stages are held, never bubbled
        bubble_flush[pipe_ctrl_pkg::stage_if]  = 1'b0;
        bubble_flush[pipe_ctrl_pkg::stage_id]  = 1'b0;
        // held predecessor but advancing stage -> insert a bubble
        bubble_flush[pipe_ctrl_pkg::stage_ex]  = stall_norm[pipe_ctrl_pkg::stage_id] &
                                                 ~stall_norm[pipe_ctrl_pkg::stage_ex];
        bubble_flush[pipe_ctrl_pkg::stage_mem] = stall_norm[pipe_ctrl_pkg::stage_ex] &
                                                 ~stall_norm[pipe_ctrl_pkg::stage_mem];
        bubble_flush[pipe_ctrl_pkg::stage_wb]  = stall_norm[pipe_ctrl_pkg::stage_mem] &
                                                 ~stall_norm[pipe_ctrl_pkg::stage_wb];
    end

    // a stall anywhere holds every earlier stage up to the first null slot
    always_comb begin
        assert final (!stall_norm[pipe_ctrl_pkg::stage_wb] ||
                      stall_norm[pipe_ctrl_pkg::stage_mem]);
        assert final (!(stall_norm[pipe_ctrl_pkg::stage_mem] && !mem_null && !ex_null) ||
                      (&stall_norm[pipe_ctrl_pkg::stage_ex:pipe_ctrl_pkg::stage_if]));
        assert final (!(stall_norm[pipe_ctrl_pkg::stage_ex] && !ex_null) ||
                      (&stall_norm[pipe_ctrl_pkg::stage_id:pipe_ctrl_pkg::stage_if]));
    end

endmodule

`default_nettype wire

/* src/exc_vector_sel.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// exception vector selector: maps exception type and CP0 state to the
// redirect target address
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`default_nettype none

module exc_vector_sel #(
    // vector base while BEV is clear
    parameter logic [31:0] normal_base = 32'h8000_0000,
    // vector base while BEV is set
    parameter logic [31:0] boot_base   = 32'hBFC0_0200
) (
    input  wire pipe_ctrl_pkg::exc_t exc_type,
    input  wire logic [31:0]         cp0_status,
    input  wire logic [31:0]         cp0_cause,
    input  wire logic [31:0]         cp0_epc,
    input  wire logic [31:0]         cp0_error_epc,
    output logic      [31:0]         exc_target
);

    logic        bev;
    logic        exl;
    logic        erl;
    logic        iv;
    logic [31:0] vec_base;

    // relevant CP0 control bits
    assign bev = cp0_status[pipe_ctrl_pkg::status_bev];
    assign exl = cp0_status[pipe_ctrl_pkg::status_exl];
    assign erl = cp0_status[pipe_ctrl_pkg::status_erl];
    assign iv  = cp0_cause[pipe_ctrl_pkg::cause_iv];

    // BEV picks bootstrap or normal vectors
    assign vec_base = bev ? boot_base : normal_base;

    always_comb begin
        case (exc_type)
            // IV moves interrupts to their dedicated vector
            pipe_ctrl_pkg::exc_intr: begin
                exc_target = vec_base +
                             (iv ? pipe_ctrl_pkg::off_intr : pipe_ctrl_pkg::off_general);
            end
            // nested refill (EXL already set) takes the general vector
            pipe_ctrl_pkg::exc_tlbr: begin
                exc_target = vec_base +
                             (exl ? pipe_ctrl_pkg::off_general : pipe_ctrl_pkg::off_refill);
            end
            // general class, bus errors are not supported
            pipe_ctrl_pkg::exc_ri,
            pipe_ctrl_pkg::exc_ov,
            pipe_ctrl_pkg::exc_trap,
            pipe_ctrl_pkg::exc_sysc,
            pipe_ctrl_pkg::exc_bp,
            pipe_ctrl_pkg::exc_ade,
            pipe_ctrl_pkg::exc_tlbi,
            pipe_ctrl_pkg::exc_tlbm,
            pipe_ctrl_pkg::exc_cpu: begin
                exc_target = vec_base + pipe_ctrl_pkg::off_general;
            end
            // return to the error PC while ERL is set
            pipe_ctrl_pkg::exc_eret: begin
                exc_target = erl ? cp0_error_epc : cp0_epc;
            end
            default: begin
                exc_target = 32'h0000_0000;
            end
        endcase
    end

    // only enumerated codes may reach the selector
    always_comb begin
        assert final (exc_type inside {pipe_ctrl_pkg::exc_none, pipe_ctrl_pkg::exc_intr,
                                       pipe_ctrl_pkg::exc_tlbr, pipe_ctrl_pkg::exc_ri,
                                       pipe_ctrl_pkg::exc_ov, pipe_ctrl_pkg::exc_trap,
                                       pipe_ctrl_pkg::exc_sysc, pipe_ctrl_pkg::exc_bp,
                                       pipe_ctrl_pkg::exc_ade, pipe_ctrl_pkg::exc_tlbi,
                                       pipe_ctrl_pkg::exc_tlbm, pipe_ctrl_pkg::exc_cpu,
                                       pipe_ctrl_pkg::exc_eret});
    end

endmodule

`default_nettype wire

/* src/ctrl_merge.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// control merge where exceptions override normal stalls, outputs registered
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`default_nettype none

module ctrl_merge (
    input  wire logic                                 clk,
    input  wire logic                                 arst_n,
    input  wire logic                                 exc_flag,
    input  wire logic [pipe_ctrl_pkg::num_stages-1:0] stall_norm,
    input  wire logic [pipe_ctrl_pkg::num_stages-1:0] bubble_flush,
    input  wire logic [31:0]                          exc_target,
    output logic      [pipe_ctrl_pkg::num_stages-1:0] stall,
    output logic      [pipe_ctrl_pkg::num_stages-1:0] flush,
    output logic      [31:0]                          redirect_pc,
    output logic                                      redirect_valid
);

    logic [pipe_ctrl_pkg::num_stages-1:0] stall_nxt;
    logic [pipe_ctrl_pkg::num_stages-1:0] flush_nxt;
    logic [31:0]                          redirect_pc_nxt;

    always_comb begin
        if (exc_flag) begin
            // exception wins so every stage is released and the pipe squashed
            stall_nxt       = '0;
            flush_nxt       = '1;
            redirect_pc_nxt = exc_target;
        end else begin
            // normal flow passes the resolver result straight through
            stall_nxt       = stall_norm;
            flush_nxt       = bubble_flush;
            redirect_pc_nxt = 32'h0000_0000;
        end
    end

    // one cycle of latency on every output
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            stall          <= '0;
            flush          <= '0;
            redirect_pc    <= 32'h0000_0000;
            redirect_valid <= 1'b0;
        end else begin
            stall          <= stall_nxt;
            flush          <= flush_nxt;
            redirect_pc    <= redirect_pc_nxt;
            // strobe follows the exception flag
            redirect_valid <= exc_flag;
        end
    end

    // a redirect never leaves any stage stalled
    redirect_no_stall_a : assert property (
        @(posedge clk) disable iff (!arst_n)
        redirect_valid |-> (stall == '0)
    );

    // a redirect always flushes every stage
    redirect_full_flush_a : assert property (
        @(posedge clk) disable iff (!arst_n)
        redirect_valid |-> (&flush)
    );

endmodule

`default_nettype wire

/* src/pipe_ctrl_top.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// pipeline stall / flush / exception redirect controller, top level
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`default_nettype none

module pipe_ctrl_top #(
    parameter logic [31:0] normal_base = 32'h8000_0000,
    parameter logic [31:0] boot_base   = 32'hBFC0_0200
) (
    input  wire logic                                 clk,
    input  wire logic                                 arst_n,
    input  wire logic [pipe_ctrl_pkg::num_stages-1:0] stall_req,
    input  wire logic                                 ex_null,
    input  wire logic                                 mem_null,
    input  wire logic                                 exc_flag,
    input  wire pipe_ctrl_pkg::exc_t                  exc_type,
    input  wire logic [31:0]                          cp0_status,
    input  wire logic [31:0]                          cp0_cause,
    input  wire logic [31:0]                          cp0_epc,
    input  wire logic [31:0]                          cp0_error_epc,
    output logic      [pipe_ctrl_pkg::num_stages-1:0] stall,
    output logic      [pipe_ctrl_pkg::num_stages-1:0] flush,
    output logic      [31:0]                          redirect_pc,
    output logic                                      redirect_valid
);

    // resolver and selector outputs, both combinational
    logic [pipe_ctrl_pkg::num_stages-1:0] stall_norm;
    logic [pipe_ctrl_pkg::num_stages-1:0] bubble_flush;
    logic [31:0]                          exc_target;

    stall_resolver u_stall_resolver (
        .stall_req    (stall_req),
        .ex_null      (ex_null),
        .mem_null     (mem_null),
        .stall_norm   (stall_norm),
        .bubble_flush (bubble_flush)
    );

    exc_vector_sel #(
        .normal_base (normal_base),
        .boot_base   (boot_base)
    ) u_exc_vector_sel (
        .exc_type      (exc_type),
        .cp0_status    (cp0_status),
        .cp0_cause     (cp0_cause),
        .cp0_epc       (cp0_epc),
        .cp0_error_epc (cp0_error_epc),
        .exc_target    (exc_target)
    );

    // priority merge and output registers
    ctrl_merge u_ctrl_merge (
        .clk            (clk),
        .arst_n         (arst_n),
        .exc_flag       (exc_flag),
        .stall_norm     (stall_norm),
        .bubble_flush   (bubble_flush),
        .exc_target     (exc_target),
        .stall          (stall),
        .flush          (flush),
        .redirect_pc    (redirect_pc),
        .redirect_valid (redirect_valid)
    );

endmodule

`default_nettype wire

/* verification/pipe_ctrl_tb.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// testbench for the pipeline stall / flush / redirect controller with LFSR
// stimulus, a reference model registered one cycle and concurrent checks
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`default_nettype none

module pipe_ctrl_tb;

    localparam logic [31:0] normal_base   = 32'h8000_0000;
    localparam logic [31:0] boot_base     = 32'hBFC0_0200;
    localparam int          random_cycles = 400;
    // reset plus random phase plus 13 types x 4 combos plus drain and margin
    localparam int          max_cycles    = 600;

    logic                clk;
    logic                arst_n;
    logic [4:0]          stall_req;
    logic                ex_null;
    logic                mem_null;
    logic                exc_flag;
    pipe_ctrl_pkg::exc_t exc_type;
    logic [31:0]         cp0_status;
    logic [31:0]         cp0_cause;
    logic [31:0]         cp0_epc;
    logic [31:0]         cp0_error_epc;
    logic [4:0]          stall;
    logic [4:0]          flush;
    logic [31:0]         redirect_pc;
    logic                redirect_valid;

    // reference outputs lag the inputs by one cycle like the DUT
    logic [4:0]          exp_stall;
    logic [4:0]          exp_flush;
    logic [31:0]         exp_pc;
    logic                exp_valid;

    logic [31:0]         lfsr_state;
    int                  cycle_count;
    int                  error_count;

    pipe_ctrl_top #(
        .normal_base (normal_base),
        .boot_base   (boot_base)
    ) DUT (
        .clk            (clk),
        .arst_n         (arst_n),
        .stall_req      (stall_req),
        .ex_null        (ex_null),
        .mem_null       (mem_null),
        .exc_flag       (exc_flag),
        .exc_type       (exc_type),
        .cp0_status     (cp0_status),
        .cp0_cause      (cp0_cause),
        .cp0_epc        (cp0_epc),
        .cp0_error_epc  (cp0_error_epc),
        .stall          (stall),
        .flush          (flush),
        .redirect_pc    (redirect_pc),
        .redirect_valid (redirect_valid)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
    end

    // x^32 + x^22 + x^2 + x + 1 shifting left
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // one LFSR step per bit with the newest bit in the lsb
    task automatic take_bits(input int n, output logic [31:0] val);
        val = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            val        = {val[30:0], lfsr_state[0]};
        end
    endtask

    // stage order IF=0 ID=1 EX=2 MEM=3 WB=4 resolved from WB back to IF
    function automatic logic [4:0] ref_stall(input logic [4:0] req, input logic exn,
                                             input logic memn);
        logic [4:0] s;
        s[4] = req[4];
        s[3] = req[3] || s[4];
        // a null slot below absorbs the stall
        s[2] = req[2] || req[0] || (s[3] && !memn);
        s[1] = req[1] || req[0] || (s[2] && !exn);
        s[0] = s[1];
        return s;
    endfunction

    // bubble into EX..WB when the stage behind is held and this one moves
    function automatic logic [4:0] ref_flush(input logic [4:0] s);
        logic [4:0] f;
        f = 5'b00000;
        for (int i = 2; i < 5; i++) begin
            f[i] = s[i-1] && !s[i];
        end
        return f;
    endfunction

    function automatic logic [31:0] ref_target(input pipe_ctrl_pkg::exc_t code,
                                               input logic [31:0] status,
                                               input logic [31:0] cause,
                                               input logic [31:0] epc,
                                               input logic [31:0] error_epc);
        logic [31:0] base;
        logic [31:0] target;
        // status bit 22 is BEV
        base = status[22] ? boot_base : normal_base;
        case (code)
            pipe_ctrl_pkg::exc_none: target = 32'h0000_0000;
            // cause bit 23 is IV
            pipe_ctrl_pkg::exc_intr: target = base + (cause[23] ? 32'h200 : 32'h180);
            // status bit 1 is EXL
            pipe_ctrl_pkg::exc_tlbr: target = base + (status[1] ? 32'h180 : 32'h000);
            // status bit 2 is ERL
            pipe_ctrl_pkg::exc_eret: target = status[2] ? error_epc : epc;
            default:                 target = base + 32'h180;
        endcase
        return target;
    endfunction

    always @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            exp_stall <= 5'b00000;
            exp_flush <= 5'b00000;
            exp_pc    <= 32'h0000_0000;
            exp_valid <= 1'b0;
        end else begin
            if (exc_flag) begin
                exp_stall <= 5'b00000;
                exp_flush <= 5'b11111;
                exp_pc    <= ref_target(exc_type, cp0_status, cp0_cause, cp0_epc,
                                        cp0_error_epc);
            end else begin
                exp_stall <= ref_stall(stall_req, ex_null, mem_null);
                exp_flush <= ref_flush(ref_stall(stall_req, ex_null, mem_null));
                exp_pc    <= 32'h0000_0000;
            end
            exp_valid <= exc_flag;
        end
    end

    task automatic value_error(input string name, input logic [31:0] exp_val,
                               input logic [31:0] act_val);
        $display("** Error at %0t: %s expected 0x%08h, actual 0x%08h",
                 $time, name, exp_val, act_val);
        error_count++;
    endtask

    // reference regs share the reset so outputs are checked through reset too
    stall_check_a : assert property (@(posedge clk) stall == exp_stall)
        else value_error("stall", 32'($sampled(exp_stall)), 32'($sampled(stall)));
    flush_check_a : assert property (@(posedge clk) flush == exp_flush)
        else value_error("flush", 32'($sampled(exp_flush)), 32'($sampled(flush)));
    pc_check_a : assert property (@(posedge clk) redirect_pc == exp_pc)
        else value_error("redirect_pc", $sampled(exp_pc), $sampled(redirect_pc));
    valid_check_a : assert property (@(posedge clk) redirect_valid == exp_valid)
        else value_error("redirect_valid", 32'($sampled(exp_valid)),
                         32'($sampled(redirect_valid)));

    // each request bit set about one time in four
    task automatic drive_random_cycle();
        logic [31:0] r;
        @(posedge clk);
        #1;
        for (int i = 0; i < 5; i++) begin
            take_bits(2, r);
            stall_req[i] = (r[1:0] == 2'b11);
        end
        take_bits(1, r);
        ex_null = r[0];
        take_bits(1, r);
        mem_null = r[0];
        take_bits(2, r);
        exc_flag = (r[1:0] == 2'b00);
        take_bits(5, r);
        exc_type = pipe_ctrl_pkg::exc_t'(r[4:0] % 5'd13);
        take_bits(32, r);
        cp0_status = r;
        take_bits(32, r);
        cp0_cause = r;
        take_bits(32, r);
        cp0_epc = r;
        take_bits(32, r);
        cp0_error_epc = r;
    endtask

    // combo[1] drives BEV and combo[0] drives EXL, ERL and IV together
    task automatic drive_exception(input logic [4:0] code, input logic [1:0] combo);
        drive_random_cycle();
        exc_flag                                = 1'b1;
        exc_type                                = pipe_ctrl_pkg::exc_t'(code);
        cp0_status[pipe_ctrl_pkg::status_bev]   = combo[1];
        cp0_status[pipe_ctrl_pkg::status_exl]   = combo[0];
        cp0_status[pipe_ctrl_pkg::status_erl]   = combo[0];
        cp0_cause[pipe_ctrl_pkg::cause_iv]      = combo[0];
    endtask

    // watchdog on the cycle counter
    initial begin
        wait (cycle_count >= max_cycles);
        $display("timeout after %0d cycles, stimulus did not complete", cycle_count);
        $display("FAIL: see errors above");
        $finish;
    end

    initial begin
        cycle_count   = 0;
        error_count   = 0;
        lfsr_state    = 32'h24e94607;
        arst_n        = 1'b0;
        stall_req     = 5'b00000;
        ex_null       = 1'b0;
        mem_null      = 1'b0;
        exc_flag      = 1'b0;
        exc_type      = pipe_ctrl_pkg::exc_none;
        cp0_status    = 32'h0000_0000;
        cp0_cause     = 32'h0000_0000;
        cp0_epc       = 32'h0000_0000;
        cp0_error_epc = 32'h0000_0000;
        repeat (3) @(posedge clk);
        #1;
        arst_n = 1'b1;
        for (int n = 0; n < random_cycles; n++) begin
            drive_random_cycle();
        end
        // every type under all four bev / level-bit combinations
        for (int t = 0; t < 13; t++) begin
            for (int c = 0; c < 4; c++) begin
                drive_exception(5'(t), 2'(c));
            end
        end
        @(posedge clk);
        #1;
        exc_flag  = 1'b0;
        stall_req = 5'b00000;
        // let the last registered result reach its check
        repeat (2) @(posedge clk);
        #1;
        $display("cycles run %0d, errors %0d", cycle_count, error_count);
        if (error_count == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* files.f */
common/pipe_ctrl_pkg.sv
src/stall_resolver.sv
src/exc_vector_sel.sv
src/ctrl_merge.sv
src/pipe_ctrl_top.sv
verification/pipe_ctrl_tb.sv

/* run.sh */
#!/bin/sh
# build and run the pipeline controller testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module pipe_ctrl_tb -f files.f

out=$(./obj_dir/Vpipe_ctrl_tb)
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qx 'PASS: all tests'; then
    exit 0
fi
exit 1
